/* sources.f */
rtl/rv_id_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_operand_fwd.sv
rtl/rv_branch_pred.sv
rtl/rv_id_ex_reg.sv
rtl/rv_stage_id.sv
tests/tb_clock_gen.sv
tests/tb_stage_id.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_stage_id
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(FLAGS) -f sources.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_stage_id.sv */
`timescale 1ns/1ps

module tb_stage_id;

  logic                 clk;
  logic                 reset_i;
  rv_id_pkg::if_id_t    if_id_i;
  rv_id_pkg::wb_write_t wb_i;
  logic                 dmem_stall_i;
  rv_id_pkg::mem_fwd_t  mem_fwd_i;
  logic                 stall_i;
  logic                 flush_i;
  logic                 bubble_i;
  rv_id_pkg::id_ctrl_t  ex_ctrl_o;
  rv_id_pkg::id_data_t  ex_data_o;
  rv_id_pkg::reg_addr_t rs1_o;
  rv_id_pkg::reg_addr_t rs2_o;
  logic                 rs1_used_o;
  logic                 rs2_used_o;
  rv_id_pkg::pc_sel_e   pc_sel_o;
  rv_id_pkg::word_t     pred_tgt_o;
  int                   errors;
  logic [31:0]          lfsr_state;

  tb_clock_gen u_clock_gen (.clk(clk), .reset_i(reset_i));

  rv_stage_id u_dut (
    .clk(clk), .reset_i(reset_i), .if_id_i(if_id_i), .wb_i(wb_i),
    .dmem_stall_i(dmem_stall_i), .mem_fwd_i(mem_fwd_i), .stall_i(stall_i),
    .flush_i(flush_i), .bubble_i(bubble_i), .ex_ctrl_o(ex_ctrl_o),
    .ex_data_o(ex_data_o), .rs1_o(rs1_o), .rs2_o(rs2_o), .rs1_used_o(rs1_used_o),
    .rs2_used_o(rs2_used_o), .pc_sel_o(pc_sel_o), .pred_tgt_o(pred_tgt_o)
  );

  // ======================================================================
  // Helpers
  // ======================================================================

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic drive_instr(input rv_id_pkg::instr_t instr, input rv_id_pkg::word_t pc);
    @(negedge clk);
    if_id_i.valid    = 1'b1;
    if_id_i.instr    = instr;
    if_id_i.pc       = pc;
    if_id_i.pc_plus4 = pc + 32'd4;
  endtask

  // Outputs are settled shortly after the edge
  task automatic sample_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] val, input logic stall);
    @(negedge clk);
    wb_i         = '{reg_write: 1'b1, rd: rd, data: val};
    dmem_stall_i = stall;
    @(negedge clk);
    wb_i         = '0;
    dmem_stall_i = 1'b0;
  endtask

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_id_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rv_id_pkg::OPC_BRANCH};
  endfunction

  // ======================================================================
  // Tests
  // ======================================================================

  task automatic test_reset();
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      #1;
      check_val("ex_ctrl_o", 32'(ex_ctrl_o), 32'h0);
      cnt++;
    end while (reset_i && cnt < 100);
    if (reset_i) begin
      $display("Reset was never released");
      errors++;
    end
    check_val("ex_ctrl_o", 32'(ex_ctrl_o), 32'h0);
  endtask

  task automatic test_decode();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    rand_bits(32, r);
    rd  = r[4:0];
    rs1 = r[9:5];
    // ADDI
    drive_instr({r[31:20], rs1, 3'b000, rd, rv_id_pkg::OPC_OP_IMM}, 32'h100);
    sample_edge();
    check_val("imm", ex_data_o.imm, {{20{r[31]}}, r[31:20]});
    check_val("rd", 32'(ex_data_o.rd), 32'(rd));
    check_val("rs1", 32'(ex_data_o.rs1), 32'(rs1));
    check_val("alu_b_src", 32'(ex_data_o.alu_b_src), 32'(rv_id_pkg::ALU_B_IMM));
    check_val("alu_op", 32'(ex_data_o.alu_op), 32'(rv_id_pkg::ALU_OP_FUNCT));
    check_val("reg_write", 32'(ex_ctrl_o.reg_write), 32'h1);
    check_val("valid", 32'(ex_ctrl_o.valid), 32'h1);
    check_val("rs1_o", 32'(rs1_o), 32'(rs1));
    check_val("rs1_used_o", 32'(rs1_used_o), 32'h1);
    check_val("rs2_used_o", 32'(rs2_used_o), 32'h0);
    // LUI
    drive_instr({r[31:12], rd, rv_id_pkg::OPC_LUI}, 32'h104);
    sample_edge();
    check_val("imm", ex_data_o.imm, {r[31:12], 12'h0});
    check_val("res_src", 32'(ex_data_o.res_src), 32'(rv_id_pkg::RES_IMM));
    check_val("alu_a_src", 32'(ex_data_o.alu_a_src), 32'(rv_id_pkg::ALU_A_ZERO));
    check_val("rs1_used_o", 32'(rs1_used_o), 32'h0);
    check_val("rs2_used_o", 32'(rs2_used_o), 32'h0);
    // SW
    drive_instr({r[31:25], r[14:10], rs1, 3'b010, r[4:0], rv_id_pkg::OPC_STORE}, 32'h108);
    sample_edge();
    check_val("imm", ex_data_o.imm, {{20{r[31]}}, r[31:25], r[4:0]});
    check_val("mem_write", 32'(ex_ctrl_o.mem_write), 32'h1);
    check_val("reg_write", 32'(ex_ctrl_o.reg_write), 32'h0);
    check_val("funct3", 32'(ex_data_o.funct3), 32'h2);
    check_val("rs2_o", 32'(rs2_o), 32'(r[14:10]));
    check_val("rs1_used_o", 32'(rs1_used_o), 32'h1);
    check_val("rs2_used_o", 32'(rs2_used_o), 32'h1);
    // SUB
    drive_instr(enc_r(7'b0100000, r[14:10], rs1, 3'b000, rd), 32'h10c);
    sample_edge();
    check_val("funct7", 32'(ex_data_o.funct7), 32'h20);
    check_val("rs2", 32'(ex_data_o.rs2), 32'(r[14:10]));
    check_val("alu_b_src", 32'(ex_data_o.alu_b_src), 32'(rv_id_pkg::ALU_B_RS2));
    check_val("trap", 32'(ex_ctrl_o.trap), 32'h0);
    check_val("rs1_o", 32'(rs1_o), 32'(rs1));
    check_val("rs2_o", 32'(rs2_o), 32'(r[14:10]));
    // EBREAK
    drive_instr(32'h0010_0073, 32'h110);
    sample_edge();
    check_val("is_ebreak", 32'(ex_data_o.is_ebreak), 32'h1);
    check_val("trap", 32'(ex_ctrl_o.trap), 32'h0);
    // custom-0 opcode is not RV32I
    drive_instr({r[31:7], 7'b0001011}, 32'h114);
    sample_edge();
    check_val("trap", 32'(ex_ctrl_o.trap), 32'h1);
    check_val("trap_code", 32'(ex_data_o.trap_code), 32'(rv_id_pkg::TRAP_INSTR_INVALID));
    check_val("reg_write", 32'(ex_ctrl_o.reg_write), 32'h0);
  endtask

  task automatic test_regfile();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] a;
    logic [4:0]  r1;
    logic [4:0]  r2;
    rand_bits(5, a);
    r1 = (a[4:0] == 5'd0) ? 5'd1 : a[4:0];
    r2 = (r1 == 5'd31) ? 5'd2 : r1 + 5'd1;
    rand_bits(32, v1);
    rand_bits(32, v2);
    rand_bits(32, v3);
    write_reg(r1, v1, 1'b0);
    write_reg(r2, v2, 1'b0);
    write_reg(5'd0, v3, 1'b0);
    drive_instr(enc_r(7'h0, r2, r1, 3'b000, 5'd3), 32'h200);
    sample_edge();
    check_val("rs1_data", ex_data_o.rs1_data, v1);
    check_val("rs2_data", ex_data_o.rs2_data, v2);
    drive_instr(enc_r(7'h0, 5'd0, 5'd0, 3'b000, 5'd3), 32'h204);
    sample_edge();
    check_val("rs1_data", ex_data_o.rs1_data, 32'h0);
    // Write under dmem stall is dropped
    write_reg(r1, v3, 1'b1);
    drive_instr(enc_r(7'h0, r2, r1, 3'b000, 5'd3), 32'h208);
    sample_edge();
    check_val("rs1_data", ex_data_o.rs1_data, v1);
    // Same-cycle write and read
    drive_instr(enc_r(7'h0, r2, r1, 3'b000, 5'd3), 32'h20c);
    wb_i = '{reg_write: 1'b1, rd: r2, data: v3};
    sample_edge();
    check_val("rs2_data", ex_data_o.rs2_data, v3);
    @(negedge clk);
    wb_i = '0;
  endtask

  task automatic test_forward();
    logic [31:0] res;
    logic [31:0] ld;
    rand_bits(32, res);
    rand_bits(32, ld);
    write_reg(5'd5, 32'h1111_1111, 1'b0);
    drive_instr(enc_r(7'h0, 5'd5, 5'd5, 3'b000, 5'd3), 32'h300);
    mem_fwd_i = '{reg_write: 1'b1, rd: 5'd5, res_src: rv_id_pkg::RES_LOAD,
                  result: res, ld_data: ld};
    sample_edge();
    check_val("rs1_data", ex_data_o.rs1_data, ld);
    check_val("rs2_data", ex_data_o.rs2_data, ld);
    @(negedge clk);
    mem_fwd_i.res_src = rv_id_pkg::RES_ALU;
    sample_edge();
    check_val("rs1_data", ex_data_o.rs1_data, res);
    drive_instr(enc_r(7'h0, 5'd0, 5'd0, 3'b000, 5'd3), 32'h304);
    mem_fwd_i.rd = 5'd0;
    sample_edge();
    check_val("rs1_data", ex_data_o.rs1_data, 32'h0);
    @(negedge clk);
    mem_fwd_i = '0;
  endtask

  task automatic test_flow();
    rv_id_pkg::id_ctrl_t addi_ctrl;
    addi_ctrl           = '0;
    addi_ctrl.valid     = 1'b1;
    addi_ctrl.reg_write = 1'b1;
    drive_instr(32'h0050_0093, 32'h400);
    sample_edge();
    check_val("ex_ctrl_o", 32'(ex_ctrl_o), 32'(addi_ctrl));
    // SW x7, 0(x0) has different control bits than the held ADDI
    drive_instr(32'h0070_2023, 32'h404);
    stall_i = 1'b1;
    sample_edge();
    check_val("ex_ctrl_o", 32'(ex_ctrl_o), 32'(addi_ctrl));
    check_val("instr", ex_data_o.instr, 32'h0050_0093);
    @(negedge clk);
    stall_i  = 1'b0;
    bubble_i = 1'b1;
    sample_edge();
    check_val("valid", 32'(ex_ctrl_o.valid), 32'h0);
    @(negedge clk);
    bubble_i = 1'b0;
    sample_edge();
    check_val("valid", 32'(ex_ctrl_o.valid), 32'h1);
    check_val("mem_write", 32'(ex_ctrl_o.mem_write), 32'h1);
    @(negedge clk);
    stall_i = 1'b1;
    flush_i = 1'b1;
    sample_edge();
    check_val("valid", 32'(ex_ctrl_o.valid), 32'h0);
    @(negedge clk);
    stall_i = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic check_pred(input logic [31:0] instr, input logic [31:0] imm, input logic taken);
    logic [31:0] pc;
    rand_bits(16, pc);
    pc = {16'h0, pc[15:2], 2'b00};
    drive_instr(instr, pc);
    #1;
    check_val("pc_sel_o", 32'(pc_sel_o),
              taken ? 32'(rv_id_pkg::PC_SEL_PRED) : 32'(rv_id_pkg::PC_SEL_SEQ));
    check_val("pred_tgt_o", pred_tgt_o, pc + imm);
    sample_edge();
    check_val("bpred_taken", 32'(ex_ctrl_o.bpred_taken), 32'(taken));
    check_val("pred_tgt", ex_data_o.pred_tgt, pc + imm);
  endtask

  task automatic test_predict();
    logic [31:0] r;
    logic [12:0] bimm;
    logic [20:0] jimm;
    rand_bits(11, r);
    bimm = {1'b1, r[10:0], 1'b0};
    check_pred(enc_b(bimm, 5'd1, 5'd2), {{19{1'b1}}, bimm}, 1'b1);
    bimm = {1'b0, r[10:0], 1'b0};
    check_pred(enc_b(bimm, 5'd1, 5'd2), {19'h0, bimm}, 1'b0);
    jimm = {1'b0, r[10:0], 9'h0};
    check_pred({jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd1, rv_id_pkg::OPC_JAL},
               {11'h0, jimm}, 1'b1);
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    errors       = 0;
    lfsr_state   = 32'h4fd5;
    if_id_i      = '{valid: 1'b1, instr: rv_id_pkg::I_NOP, pc: 32'h0, pc_plus4: 32'h4};
    wb_i         = '0;
    dmem_stall_i = 1'b0;
    mem_fwd_i    = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    bubble_i     = 1'b0;
    test_reset();
    test_decode();
    test_regfile();
    test_forward();
    test_flow();
    test_predict();
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog against a stuck run
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    $display("Simulation did not finish within 5000 cycles");
    $display("Verification failed");
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset_i
);

  initial begin
    clk     = 1'b0;
    reset_i = 1'b1;
    // Reset covers the first 16 rising edges
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;
  end

  always #5 clk = ~clk;

endmodule

/* rtl/rv_stage_id.sv */
`timescale 1ns/1ps

module rv_stage_id (
  input  logic                 clk,
  input  logic                 reset_i,

  // Fetch and write-back
  input  rv_id_pkg::if_id_t    if_id_i,
  input  rv_id_pkg::wb_write_t wb_i,
  input  logic                 dmem_stall_i,
  input  rv_id_pkg::mem_fwd_t  mem_fwd_i,

  // Hazard unit
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  logic                 bubble_i,

  output rv_id_pkg::id_ctrl_t  ex_ctrl_o,
  output rv_id_pkg::id_data_t  ex_data_o,
  output rv_id_pkg::reg_addr_t rs1_o,
  output rv_id_pkg::reg_addr_t rs2_o,
  output logic                 rs1_used_o,
  output logic                 rs2_used_o,
  output rv_id_pkg::pc_sel_e   pc_sel_o,
  output rv_id_pkg::word_t     pred_tgt_o
);

  rv_id_pkg::id_ctrl_t dec_ctrl;
  rv_id_pkg::id_data_t dec_data;
  rv_id_pkg::id_ctrl_t id_ctrl;
  rv_id_pkg::id_data_t id_data;
  rv_id_pkg::word_t    rf_rs1_data;
  rv_id_pkg::word_t    rf_rs2_data;
  rv_id_pkg::word_t    fwd_rs1_data;
  rv_id_pkg::word_t    fwd_rs2_data;
  rv_id_pkg::word_t    pred_tgt;
  logic                pred_taken;

  assign rs1_o      = dec_data.rs1;
  assign rs2_o      = dec_data.rs2;
  assign pred_tgt_o = pred_tgt;

  rv_decoder u_decoder (
    .instr_i    (if_id_i.instr),
    .ctrl_o     (dec_ctrl),
    .data_o     (dec_data),
    .rs1_used_o (rs1_used_o),
    .rs2_used_o (rs2_used_o)
  );

  rv_regfile u_regfile (
    .clk          (clk),
    .rs1_i        (dec_data.rs1),
    .rs2_i        (dec_data.rs2),
    .rs1_data_o   (rf_rs1_data),
    .rs2_data_o   (rf_rs2_data),
    .wb_i         (wb_i),
    .dmem_stall_i (dmem_stall_i)
  );

  rv_operand_fwd u_operand_fwd (
    .rs1_i      (dec_data.rs1),
    .rs2_i      (dec_data.rs2),
    .rs1_data_i (rf_rs1_data),
    .rs2_data_i (rf_rs2_data),
    .mem_fwd_i  (mem_fwd_i),
    .rs1_data_o (fwd_rs1_data),
    .rs2_data_o (fwd_rs2_data)
  );

  // An empty fetch slot must not redirect fetch
  rv_branch_pred u_branch_pred (
    .pc_i         (if_id_i.pc),
    .imm_i        (dec_data.imm),
    .is_branch_i  (dec_ctrl.is_branch && if_id_i.valid),
    .is_jal_i     (dec_ctrl.is_jal && if_id_i.valid),
    .pc_sel_o     (pc_sel_o),
    .pred_tgt_o   (pred_tgt),
    .pred_taken_o (pred_taken)
  );

  // ======================================================================
  // ID/EX bundle
  // ======================================================================

  always_comb begin
    id_ctrl             = dec_ctrl;
    id_ctrl.valid       = if_id_i.valid;
    id_ctrl.bpred_taken = pred_taken;

    id_data          = dec_data;
    id_data.pc       = if_id_i.pc;
    id_data.pc_plus4 = if_id_i.pc_plus4;
    id_data.rs1_data = fwd_rs1_data;
    id_data.rs2_data = fwd_rs2_data;
    id_data.pred_tgt = pred_tgt;
    id_data.instr    = if_id_i.instr;
  end

  rv_id_ex_reg u_id_ex_reg (
    .clk      (clk),
    .reset_i  (reset_i),
    .stall_i  (stall_i),
    .flush_i  (flush_i),
    .bubble_i (bubble_i),
    .ctrl_i   (id_ctrl),
    .data_i   (id_data),
    .ctrl_o   (ex_ctrl_o),
    .data_o   (ex_data_o)
  );

endmodule

/* rtl/rv_id_ex_reg.sv */
`timescale 1ns/1ps

module rv_id_ex_reg (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                stall_i,
  input  logic                flush_i,
  input  logic                bubble_i,
  input  rv_id_pkg::id_ctrl_t ctrl_i,
  input  rv_id_pkg::id_data_t data_i,
  output rv_id_pkg::id_ctrl_t ctrl_o,
  output rv_id_pkg::id_data_t data_o
);

  rv_id_pkg::id_ctrl_t ctrl_q;
  rv_id_pkg::id_data_t data_q;

  // ======================================================================
  // Control half
  // ======================================================================

  // Flush wins over stall, stall wins over bubble
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      ctrl_q <= '0;
    end else if (!stall_i) begin
      if (bubble_i) begin
        ctrl_q <= '0;
      end else begin
        ctrl_q <= ctrl_i;
      end
    end
  end

  // ======================================================================
  // Datapath half
  // ======================================================================

  // A bubble still loads the datapath, it is ignored behind valid 0
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      data_q <= data_i;
      if (bubble_i) begin
        data_q.instr <= rv_id_pkg::I_NOP;
      end
    end
  end

  assign ctrl_o = ctrl_q;
  assign data_o = data_q;

  // EX may rely on a held instruction staying put across a stall
  a_stall_holds_ctrl: assert property (@(posedge clk) disable iff (reset_i)
    (ctrl_o.valid && stall_i && !flush_i) |=> (ctrl_o == $past(ctrl_o)));

  // Nothing leaves the stage as valid straight out of reset
  a_reset_clears_ctrl: assert property (@(posedge clk)
    reset_i |=> (ctrl_o == '0));

endmodule

/* rtl/rv_branch_pred.sv */
`timescale 1ns/1ps

module rv_branch_pred (
  input  rv_id_pkg::word_t   pc_i,
  input  rv_id_pkg::word_t   imm_i,
  input  logic               is_branch_i,
  input  logic               is_jal_i,
  output rv_id_pkg::pc_sel_e pc_sel_o,
  output rv_id_pkg::word_t   pred_tgt_o,
  output logic               pred_taken_o
);

  logic taken;

  // Backward taken, forward not taken; JAL always redirects
  assign taken = is_jal_i || (is_branch_i && imm_i[rv_id_pkg::XLEN-1]);

  // JALR depends on rs1 and is left to EX
  assign pred_tgt_o   = pc_i + imm_i;
  assign pred_taken_o = taken;

  always_comb begin
    if (taken) begin
      pc_sel_o = rv_id_pkg::PC_SEL_PRED;
    end else begin
      pc_sel_o = rv_id_pkg::PC_SEL_SEQ;
    end
  end

endmodule

/* rtl/rv_operand_fwd.sv */
`timescale 1ns/1ps

module rv_operand_fwd (
  input  rv_id_pkg::reg_addr_t rs1_i,
  input  rv_id_pkg::reg_addr_t rs2_i,
  input  rv_id_pkg::word_t     rs1_data_i,
  input  rv_id_pkg::word_t     rs2_data_i,
  input  rv_id_pkg::mem_fwd_t  mem_fwd_i,
  output rv_id_pkg::word_t     rs1_data_o,
  output rv_id_pkg::word_t     rs2_data_o
);

  rv_id_pkg::word_t mem_val;
  logic             mem_writes;
  logic             hit_rs1;
  logic             hit_rs2;

  // Loads return their data late, so pick ld_data instead of the ALU result
  assign mem_val = (mem_fwd_i.res_src == rv_id_pkg::RES_LOAD) ?
                   mem_fwd_i.ld_data : mem_fwd_i.result;

  // Writes to x0 are never forwarded
  assign mem_writes = mem_fwd_i.reg_write && (mem_fwd_i.rd != '0);

  assign hit_rs1 = mem_writes && (mem_fwd_i.rd == rs1_i);
  assign hit_rs2 = mem_writes && (mem_fwd_i.rd == rs2_i);

  // WB results already come through the register file bypass
  assign rs1_data_o = hit_rs1 ? mem_val : rs1_data_i;
  assign rs2_data_o = hit_rs2 ? mem_val : rs2_data_i;

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                 clk,
  input  rv_id_pkg::reg_addr_t rs1_i,
  input  rv_id_pkg::reg_addr_t rs2_i,
  output rv_id_pkg::word_t     rs1_data_o,
  output rv_id_pkg::word_t     rs2_data_o,
  input  rv_id_pkg::wb_write_t wb_i,
  input  logic                 dmem_stall_i
);

  // x0 has no storage
  rv_id_pkg::word_t regs [1:31];
  logic             wr_en;

  assign wr_en = wb_i.reg_write && !dmem_stall_i && (wb_i.rd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Write-through, a write in this cycle is already visible
  function automatic rv_id_pkg::word_t read_port(rv_id_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_en && (addr == wb_i.rd)) begin
      return wb_i.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  a_x0_reads_zero: assert property (@(posedge clk)
    ((rs1_i != '0) || (rs1_data_o == '0)) && ((rs2_i != '0) || (rs2_data_o == '0)));

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  rv_id_pkg::instr_t   instr_i,
  output rv_id_pkg::id_ctrl_t ctrl_o,
  output rv_id_pkg::id_data_t data_o,
  output logic                rs1_used_o,
  output logic                rs2_used_o
);

  logic [6:0]           opcode;
  rv_id_pkg::funct3_t   funct3;
  rv_id_pkg::funct7_t   funct7;
  rv_id_pkg::imm_type_e imm_type;
  logic                 invalid;
  rv_id_pkg::word_t     imm_i;
  rv_id_pkg::word_t     imm_s;
  rv_id_pkg::word_t     imm_b;
  rv_id_pkg::word_t     imm_u;
  rv_id_pkg::word_t     imm_j;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates for every format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ======================================================================
  // Control decode
  // ======================================================================

  always_comb begin
    ctrl_o     = '0;
    data_o     = '0;
    rs1_used_o = 1'b0;
    rs2_used_o = 1'b0;
    invalid    = 1'b0;
    imm_type   = rv_id_pkg::IMM_I;

    // Most formats add rs1 and an immediate
    data_o.alu_b_src = rv_id_pkg::ALU_B_IMM;

    case (opcode)
      rv_id_pkg::OPC_LUI: begin
        ctrl_o.reg_write = 1'b1;
        data_o.alu_a_src = rv_id_pkg::ALU_A_ZERO;
        data_o.res_src   = rv_id_pkg::RES_IMM;
        imm_type         = rv_id_pkg::IMM_U;
      end
      rv_id_pkg::OPC_AUIPC: begin
        ctrl_o.reg_write = 1'b1;
        data_o.alu_a_src = rv_id_pkg::ALU_A_PC;
        imm_type         = rv_id_pkg::IMM_U;
      end
      rv_id_pkg::OPC_JAL: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.is_jmp    = 1'b1;
        ctrl_o.is_jal    = 1'b1;
        data_o.alu_a_src = rv_id_pkg::ALU_A_PC;
        data_o.res_src   = rv_id_pkg::RES_PC4;
        imm_type         = rv_id_pkg::IMM_J;
      end
      rv_id_pkg::OPC_JALR: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.is_jmp     = 1'b1;
        ctrl_o.is_jalr    = 1'b1;
        data_o.res_src    = rv_id_pkg::RES_PC4;
        // Target base is rs1 instead of pc
        data_o.jb_tgt_src = 1'b1;
        rs1_used_o        = 1'b1;
        invalid           = (funct3 != 3'b000);
      end
      rv_id_pkg::OPC_BRANCH: begin
        ctrl_o.is_branch = 1'b1;
        data_o.alu_b_src = rv_id_pkg::ALU_B_RS2;
        data_o.alu_op    = rv_id_pkg::ALU_OP_SUB;
        imm_type         = rv_id_pkg::IMM_B;
        rs1_used_o       = 1'b1;
        rs2_used_o       = 1'b1;
        invalid          = (funct3[2:1] == 2'b01);
      end
      rv_id_pkg::OPC_LOAD: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.mem_read  = 1'b1;
        data_o.res_src   = rv_id_pkg::RES_LOAD;
        rs1_used_o       = 1'b1;
        invalid          = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv_id_pkg::OPC_STORE: begin
        ctrl_o.mem_write = 1'b1;
        imm_type         = rv_id_pkg::IMM_S;
        rs1_used_o       = 1'b1;
        rs2_used_o       = 1'b1;
        invalid          = (funct3 > 3'b010);
      end
      rv_id_pkg::OPC_OP_IMM: begin
        ctrl_o.reg_write = 1'b1;
        data_o.alu_op    = rv_id_pkg::ALU_OP_FUNCT;
        rs1_used_o       = 1'b1;
        // Shift amounts leave only funct7 of 0 or SRAI
        invalid = ((funct3 == 3'b001) && (funct7 != 7'b0000000)) ||
                  ((funct3 == 3'b101) && (funct7 != 7'b0000000) &&
                   (funct7 != 7'b0100000));
      end
      rv_id_pkg::OPC_OP: begin
        ctrl_o.reg_write = 1'b1;
        data_o.alu_b_src = rv_id_pkg::ALU_B_RS2;
        data_o.alu_op    = rv_id_pkg::ALU_OP_FUNCT;
        rs1_used_o       = 1'b1;
        rs2_used_o       = 1'b1;
        invalid = !((funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) &&
                     ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      rv_id_pkg::OPC_SYSTEM: begin
        // EBREAK is the only SYSTEM encoding handled here
        if (instr_i == 32'h0010_0073) begin
          data_o.is_ebreak = 1'b1;
        end else begin
          invalid = 1'b1;
        end
      end
      default: invalid = 1'b1;
    endcase

    // An illegal instruction has no side effects besides the trap
    if (invalid) begin
      ctrl_o           = '0;
      ctrl_o.trap      = 1'b1;
      data_o.trap_code = rv_id_pkg::TRAP_INSTR_INVALID;
    end

    data_o.rd     = instr_i[11:7];
    data_o.rs1    = instr_i[19:15];
    data_o.rs2    = instr_i[24:20];
    data_o.funct3 = funct3;
    data_o.funct7 = funct7;

    case (imm_type)
      rv_id_pkg::IMM_S: data_o.imm = imm_s;
      rv_id_pkg::IMM_B: data_o.imm = imm_b;
      rv_id_pkg::IMM_U: data_o.imm = imm_u;
      rv_id_pkg::IMM_J: data_o.imm = imm_j;
      default:          data_o.imm = imm_i;
    endcase
  end

endmodule

/* rtl/rv_id_pkg.sv */
package rv_id_pkg;

  // ======================================================================
  // Widths and basic types
  // ======================================================================

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // ADDI x0, x0, 0
  localparam instr_t I_NOP = 32'h0000_0013;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ======================================================================
  // Decoder field encodings
  // ======================================================================

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
  typedef enum logic [1:0] {ALU_A_RS1, ALU_A_ZERO, ALU_A_PC} alu_a_src_e;
  typedef enum logic {ALU_B_RS2, ALU_B_IMM} alu_b_src_e;
  // FUNCT lets EX pick the operation from funct3/funct7
  typedef enum logic [1:0] {ALU_OP_ADD, ALU_OP_SUB, ALU_OP_FUNCT} alu_op_e;
  typedef enum logic [2:0] {RES_ALU, RES_LOAD, RES_PC4, RES_IMM} res_src_e;
  typedef enum logic [1:0] {TRAP_NONE, TRAP_INSTR_INVALID} trap_code_e;
  typedef enum logic [1:0] {PC_SEL_SEQ, PC_SEL_PRED} pc_sel_e;

  // ======================================================================
  // Stage bundles
  // ======================================================================

  // Fields cleared by flush and bubble
  typedef struct packed {
    logic valid;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic is_branch;
    logic is_jmp;
    logic is_jal;
    logic is_jalr;
    logic trap;
    logic bpred_taken;
  } id_ctrl_t;

  typedef struct packed {
    alu_a_src_e alu_a_src;
    alu_b_src_e alu_b_src;
    alu_op_e    alu_op;
    res_src_e   res_src;
    logic       jb_tgt_src;
    logic       is_ebreak;
    trap_code_e trap_code;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    funct3_t    funct3;
    funct7_t    funct7;
    word_t      imm;
    word_t      pc;
    word_t      pc_plus4;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      pred_tgt;
    instr_t     instr;
  } id_data_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    res_src_e  res_src;
    word_t     result;
    word_t     ld_data;
  } mem_fwd_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
  } wb_write_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
    word_t  pc;
    word_t  pc_plus4;
  } if_id_t;

endpackage
